/* logic/mpr121_pkg.sv */
`default_nettype none

package mpr121_pkg;

	//====================================================================
	// bus constants
	//====================================================================

	// 7-bit slave address, ADDR pin tied to 3Vo
	localparam logic [6:0] SLAVE_ADDR = 7'h5B;

	// clocks per quarter scl period
	// board value is 125 (50 MHz core, 100 kHz scl)
	localparam int SCL_QUARTER = 4;
	localparam int QTR_W = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1; // quarter counter width

	typedef logic [7:0] byte_t; // register address / data

	//====================================================================
	// engine command encodings
	//====================================================================

	// bit level ops, one scl period each
	typedef enum logic [1:0]
	{
		BIT_START = 2'd0, // also the repeated start
		BIT_STOP  = 2'd1,
		BIT_WRITE = 2'd2,
		BIT_READ  = 2'd3
	} bit_op_e;

	// byte level commands
	typedef enum logic [1:0]
	{
		CMD_START      = 2'd0,
		CMD_STOP       = 2'd1,
		CMD_WRITE_BYTE = 2'd2, // 8 bits out, ack in
		CMD_READ_BYTE  = 2'd3  // 8 bits in, ack out
	} byte_op_e;

endpackage

`default_nettype wire

/* logic/i2c_bit_engine.sv */
`default_nettype none

module i2c_bit_engine
	import mpr121_pkg::*;
(
	input  wire              i_CLK,
	input  wire              i_RSTN,
	input  wire bit_op_e     i_op,
	input  wire              i_tx_bit,
	input  wire              i_valid,
	input  wire              i_scl,      // resolved bus lines
	input  wire              i_sda,
	output logic             o_ready,
	output logic             o_rx_bit,   // sda sampled at mid-high
	output logic             o_done,
	output logic             o_scl_low,  // 1 pulls scl low
	output logic             o_sda_low
);

	logic             busy;
	bit_op_e          op_q;
	logic [1:0]       phase;     // quarter of the scl period
	logic [QTR_W-1:0] qcnt;
	logic             accept;
	logic             step;      // last cycle of a quarter
	bit_op_e          op_sel;
	logic [1:0]       phase_sel; // phase being entered
	logic             scl_low_nxt;
	logic             sda_low_nxt;

	assign o_ready   = !busy;
	assign accept    = i_valid && !busy;
	assign step      = busy && (qcnt == QTR_W'(SCL_QUARTER - 1));
	assign op_sel    = accept ? i_op : op_q;
	assign phase_sel = accept ? 2'd0 : phase + 2'd1;

	//====================================================================
	// line levels on entry to each quarter
	//====================================================================
	always_comb
	begin
		scl_low_nxt = o_scl_low; // hold by default
		sda_low_nxt = o_sda_low;
		case (phase_sel)
			2'd0:
			begin
				if (op_sel == BIT_START)
					sda_low_nxt = 1'b0; // release sda and leave scl as is
				else
				begin
					scl_low_nxt = 1'b1; // sda moves only while scl low
					if (op_sel == BIT_STOP)
						sda_low_nxt = 1'b1;
					else if (op_sel == BIT_WRITE)
						sda_low_nxt = !i_tx_bit; // phase 0 entered on accept only
					else
						sda_low_nxt = 1'b0; // read lets the slave drive
				end
			end
			2'd1: scl_low_nxt = 1'b0; // scl rises
			2'd2:
			begin
				if (op_sel == BIT_START)
					sda_low_nxt = 1'b1; // falling sda with scl high
				else if (op_sel == BIT_STOP)
					sda_low_nxt = 1'b0; // rising sda with scl high
			end
			default:
			begin
				if (op_sel != BIT_STOP)
					scl_low_nxt = 1'b1; // stop leaves the bus idle
			end
		endcase
	end

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			busy      <= 1'b0;
			op_q      <= BIT_STOP;
			phase     <= 2'd0;
			qcnt      <= '0;
			o_done    <= 1'b0;
			o_rx_bit  <= 1'b0;
			o_scl_low <= 1'b0; // both lines released
			o_sda_low <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (accept)
			begin
				busy      <= 1'b1;
				op_q      <= i_op;
				phase     <= 2'd0;
				qcnt      <= '0;
				o_scl_low <= scl_low_nxt;
				o_sda_low <= sda_low_nxt;
			end
			else if (step)
			begin
				qcnt <= '0;
				if (phase == 2'd3)
				begin
					busy   <= 1'b0;
					o_done <= 1'b1; // 4 quarters after accept
				end
				else
				begin
					phase     <= phase_sel;
					o_scl_low <= scl_low_nxt;
					o_sda_low <= sda_low_nxt;
				end
			end
			else if (busy)
				qcnt <= qcnt + QTR_W'(1);

			if (busy && phase == 2'd2 && qcnt == '0)
				o_rx_bit <= i_sda; // mid-high sample
		end
	end

	// sda may only move under a high scl for start/stop
	a_sda_stable: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(!o_scl_low && !$past(o_scl_low) && $changed(o_sda_low))
		|-> (op_q == BIT_START || op_q == BIT_STOP));

	// released scl must read high
	a_scl_high: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(busy && phase == 2'd2) |-> i_scl);

endmodule

`default_nettype wire

/* logic/i2c_byte_engine.sv */
`default_nettype none

module i2c_byte_engine
	import mpr121_pkg::*;
(
	input  wire              i_CLK,
	input  wire              i_RSTN,
	input  wire byte_op_e    i_op,
	input  wire byte_t       i_tx_byte,
	input  wire              i_ack_bit,    // master ack level for reads
	input  wire              i_valid,
	output logic             o_ready,
	output byte_t            o_rx_byte,
	output logic             o_ack_missed, // valid with o_done
	output logic             o_done,
	// bit engine side
	output bit_op_e          o_bit_op,
	output logic             o_bit_tx,
	output logic             o_bit_valid,
	input  wire              i_bit_ready,
	input  wire              i_bit_rx,
	input  wire              i_bit_done
);

	logic       busy;
	byte_op_e   op_q;
	byte_t      shreg;   // tx bits out the top, rx bits in the bottom
	logic       ack_q;
	logic [3:0] bit_cnt; // 0..7 data, 8 ack slot
	logic       ninth;
	logic       single;  // start/stop, one bit op

	assign o_ready   = !busy;
	assign o_rx_byte = shreg;
	assign ninth     = (bit_cnt == 4'd8);
	assign single    = (op_q == CMD_START) || (op_q == CMD_STOP);
	assign o_bit_tx  = ninth ? ack_q : shreg[7]; // msb first

	always_comb
	begin
		case (op_q)
			CMD_START:      o_bit_op = BIT_START;
			CMD_STOP:       o_bit_op = BIT_STOP;
			CMD_WRITE_BYTE: o_bit_op = ninth ? BIT_READ : BIT_WRITE; // slave acks
			default:        o_bit_op = ninth ? BIT_WRITE : BIT_READ; // we ack
		endcase
	end

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			busy         <= 1'b0;
			op_q         <= CMD_STOP;
			bit_cnt      <= 4'd0;
			o_bit_valid  <= 1'b0;
			o_done       <= 1'b0;
			o_ack_missed <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			if (o_ready && i_valid)
			begin
				busy         <= 1'b1;
				op_q         <= i_op;
				bit_cnt      <= 4'd0;
				o_bit_valid  <= 1'b1; // first bit op right away
				o_ack_missed <= 1'b0;
			end
			else if (busy)
			begin
				if (o_bit_valid && i_bit_ready)
					o_bit_valid <= 1'b0;
				if (i_bit_done)
				begin
					if (single || ninth)
					begin
						busy   <= 1'b0;
						o_done <= 1'b1;
						if (op_q == CMD_WRITE_BYTE)
							o_ack_missed <= i_bit_rx; // high = nack
					end
					else
					begin
						bit_cnt     <= bit_cnt + 4'd1;
						o_bit_valid <= 1'b1;
					end
				end
			end
		end
	end

	// payload, no reset
	always_ff @(posedge i_CLK)
	begin
		if (o_ready && i_valid)
		begin
			shreg <= i_tx_byte;
			ack_q <= i_ack_bit;
		end
		else if (busy && i_bit_done && !single && !ninth)
			shreg <= {shreg[6:0], i_bit_rx};
	end

	// sequencer keeps one command in flight
	a_one_cmd: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		busy |-> !i_valid);

endmodule

`default_nettype wire

/* logic/mpr121_reg_access.sv */
`default_nettype none

module mpr121_reg_access
	import mpr121_pkg::*;
(
	input  wire              i_CLK,
	input  wire              i_RSTN,
	input  wire byte_t       i_reg_addr,
	input  wire byte_t       i_wdata,
	input  wire              i_write_en,
	input  wire              i_read_en,
	input  wire              i_ready,
	input  wire byte_t       i_rx_byte,
	input  wire              i_ack_missed,
	input  wire              i_done,
	output byte_op_e         o_op,
	output byte_t            o_tx_byte,
	output logic             o_ack_bit,
	output logic             o_valid,
	output byte_t            o_rdata,
	output logic             o_busy,
	output logic             o_fail
);

	typedef enum logic [3:0]
	{
		S_IDLE, S_START, S_ADDR_W, S_REG, S_DATA,
		S_RSTART, S_ADDR_R, S_RDATA, S_STOP, S_FINISH
	} state_e;

	state_e state;
	state_e next_cmd; // step after the current command
	logic   issued;   // command of this state handed over
	logic   is_read;
	byte_t  reg_addr_q;
	byte_t  wdata_q;

	//====================================================================
	// command per state
	//====================================================================
	always_comb
	begin
		o_op      = CMD_WRITE_BYTE;
		o_tx_byte = reg_addr_q;
		o_ack_bit = 1'b1; // single byte read, always nack
		next_cmd  = S_FINISH;
		case (state)
			S_START:  next_cmd = S_ADDR_W;
			S_ADDR_W:
			begin
				o_tx_byte = {SLAVE_ADDR, 1'b0}; // write direction
				next_cmd  = S_REG;
			end
			S_REG:    next_cmd = is_read ? S_RSTART : S_DATA;
			S_DATA:
			begin
				o_tx_byte = wdata_q;
				next_cmd  = S_STOP;
			end
			S_RSTART: next_cmd = S_ADDR_R;
			S_ADDR_R:
			begin
				o_tx_byte = {SLAVE_ADDR, 1'b1}; // read direction
				next_cmd  = S_RDATA;
			end
			S_RDATA:  next_cmd = S_STOP;
			default:  next_cmd = S_FINISH;
		endcase
		if (state == S_START || state == S_RSTART)
			o_op = CMD_START;
		else if (state == S_RDATA)
			o_op = CMD_READ_BYTE;
		else if (state == S_STOP)
			o_op = CMD_STOP;
	end

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			state   <= S_IDLE;
			issued  <= 1'b0;
			is_read <= 1'b0;
			o_valid <= 1'b0;
			o_rdata <= '0;
			o_busy  <= 1'b0;
			o_fail  <= 1'b0;
		end
		else if (state == S_IDLE)
		begin
			if (i_write_en || i_read_en)
			begin
				is_read <= !i_write_en; // write wins a tie
				o_fail  <= 1'b0;
				o_busy  <= 1'b1;
				state   <= S_START;
			end
		end
		else if (state == S_FINISH)
		begin
			if (is_read ? !i_read_en : !i_write_en)
				state <= S_IDLE; // one op per enable
		end
		else
		begin
			if (!issued)
			begin
				o_valid <= 1'b1;
				issued  <= 1'b1;
			end
			else if (o_valid && i_ready)
				o_valid <= 1'b0;
			if (i_done)
			begin
				issued <= 1'b0;
				state  <= next_cmd;
				if (state == S_RDATA)
					o_rdata <= i_rx_byte;
				if (state == S_STOP)
					o_busy <= 1'b0; // stop condition finished
				if (i_ack_missed)
				begin
					o_fail <= 1'b1;
					state  <= S_STOP; // drop the rest, release bus
				end
			end
		end
	end

	always_ff @(posedge i_CLK)
	begin
		if (state == S_IDLE)
		begin
			reg_addr_q <= i_reg_addr;
			wdata_q    <= i_wdata;
		end
	end

	// byte engine never works behind the host's back
	a_busy_cover: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		!i_ready |-> o_busy);

endmodule

`default_nettype wire

/* logic/mpr121_top.sv */
`default_nettype none

module mpr121_top
	import mpr121_pkg::*;
(
	input  wire              i_CLK,
	input  wire              i_RSTN,
	input  wire byte_t       i_reg_addr,
	input  wire byte_t       i_wdata,
	input  wire              i_write_en,
	input  wire              i_read_en,
	input  wire              i_scl,     // bus lines after pull-ups
	input  wire              i_sda,
	output byte_t            o_rdata,
	output logic             o_busy,
	output logic             o_fail,
	output logic             o_scl_low, // open-drain pulls
	output logic             o_sda_low
);

	// sequencer <-> byte engine
	byte_op_e cmd_op;
	byte_t    cmd_tx;
	logic     cmd_ack_bit;
	logic     cmd_valid;
	logic     cmd_ready;
	byte_t    cmd_rx;
	logic     cmd_ack_missed;
	logic     cmd_done;

	// byte engine <-> bit engine
	bit_op_e  bit_op;
	logic     bit_tx;
	logic     bit_valid;
	logic     bit_ready;
	logic     bit_rx;
	logic     bit_done;

	mpr121_reg_access u_seq (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_reg_addr   (i_reg_addr),
		.i_wdata      (i_wdata),
		.i_write_en   (i_write_en),
		.i_read_en    (i_read_en),
		.i_ready      (cmd_ready),
		.i_rx_byte    (cmd_rx),
		.i_ack_missed (cmd_ack_missed),
		.i_done       (cmd_done),
		.o_op         (cmd_op),
		.o_tx_byte    (cmd_tx),
		.o_ack_bit    (cmd_ack_bit),
		.o_valid      (cmd_valid),
		.o_rdata      (o_rdata),
		.o_busy       (o_busy),
		.o_fail       (o_fail)
	);

	i2c_byte_engine u_byte (
		.i_CLK        (i_CLK),
		.i_RSTN       (i_RSTN),
		.i_op         (cmd_op),
		.i_tx_byte    (cmd_tx),
		.i_ack_bit    (cmd_ack_bit),
		.i_valid      (cmd_valid),
		.o_ready      (cmd_ready),
		.o_rx_byte    (cmd_rx),
		.o_ack_missed (cmd_ack_missed),
		.o_done       (cmd_done),
		.o_bit_op     (bit_op),
		.o_bit_tx     (bit_tx),
		.o_bit_valid  (bit_valid),
		.i_bit_ready  (bit_ready),
		.i_bit_rx     (bit_rx),
		.i_bit_done   (bit_done)
	);

	i2c_bit_engine u_bit (
		.i_CLK     (i_CLK),
		.i_RSTN    (i_RSTN),
		.i_op      (bit_op),
		.i_tx_bit  (bit_tx),
		.i_valid   (bit_valid),
		.i_scl     (i_scl),
		.i_sda     (i_sda),
		.o_ready   (bit_ready),
		.o_rx_bit  (bit_rx),
		.o_done    (bit_done),
		.o_scl_low (o_scl_low),
		.o_sda_low (o_sda_low)
	);

endmodule

`default_nettype wire

/* dv/mpr121_slave_model.sv */
`default_nettype none

module mpr121_slave_model
	import mpr121_pkg::*;
(
	input  wire  i_CLK,
	input  wire  i_RSTN,
	input  wire  i_scl,      // resolved bus lines
	input  wire  i_sda,
	input  wire  i_nak,      // refuse every ack while high
	output logic o_sda_low   // 1 pulls sda low
);

	byte_t regs [0:255];
	byte_t shreg;    // incoming byte, msb first
	byte_t tx;       // outgoing byte, bit 7 on the line
	byte_t reg_ptr;  // register pointer, auto increments
	logic  scl_q;
	logic  sda_q;
	logic  in_xfer;  // addressed frame in progress
	logic  sending;  // read direction, slave owns the data bits
	logic  mack;     // master acked the last byte
	logic  drv;
	int    bit_cnt;  // rising scl edges in this 9-bit frame
	int    byte_idx; // bytes since the last start

	//====================================================================
	// bus sampled every clock, edges found against the last sample
	//====================================================================
	always @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			for (int i = 0; i < 256; i++)
				regs[i] = 8'(i) ^ 8'hA5; // power-up pattern
			shreg     = '0;
			tx        = '0;
			reg_ptr   = '0;
			scl_q     = 1'b1;
			sda_q     = 1'b1;
			in_xfer   = 1'b0;
			sending   = 1'b0;
			mack      = 1'b0;
			drv       = 1'b0;
			bit_cnt   = 0;
			byte_idx  = 0;
			o_sda_low <= 1'b0;
		end
		else
		begin
			drv = o_sda_low;
			if (scl_q && i_scl && sda_q && !i_sda)
			begin
				in_xfer  = 1'b1; // start or repeated start
				sending  = 1'b0;
				bit_cnt  = 0;
				byte_idx = 0;
				drv      = 1'b0;
			end
			else if (scl_q && i_scl && !sda_q && i_sda)
			begin
				in_xfer = 1'b0; // stop
				sending = 1'b0;
				drv     = 1'b0;
			end
			else if (in_xfer && !scl_q && i_scl)
			begin
				if (bit_cnt < 8)
					shreg = {shreg[6:0], i_sda};
				else if (sending)
					mack = !i_sda; // our own ack reads low after the address
				bit_cnt++;
			end
			else if (in_xfer && scl_q && !i_scl)
			begin
				if (bit_cnt == 8 && sending)
					drv = 1'b0; // let the master ack
				else if (bit_cnt == 8)
				begin
					drv = !i_nak;
					if (byte_idx == 0)
					begin
						drv     = drv && (shreg[7:1] == SLAVE_ADDR);
						sending = drv && shreg[0];
					end
					else if (byte_idx == 1)
						reg_ptr = shreg;
					else if (drv)
					begin
						regs[reg_ptr] = shreg;
						reg_ptr++;
					end
					if (!drv)
						in_xfer = 1'b0; // refused, wait for the next start
					byte_idx++;
				end
				else if (bit_cnt == 9)
				begin
					bit_cnt = 0;
					drv     = 1'b0; // ack slot over
					if (sending && mack)
					begin
						tx = regs[reg_ptr];
						reg_ptr++;
						drv = !tx[7];
					end
					else if (sending)
					begin
						sending = 1'b0; // master nack ends the read
						in_xfer = 1'b0;
					end
				end
				else if (sending && bit_cnt > 0)
				begin
					tx  = {tx[6:0], 1'b0};
					drv = !tx[7];
				end
			end
			scl_q = i_scl;
			sda_q = i_sda;
			o_sda_low <= drv;
		end
	end

endmodule

`default_nettype wire

/* dv/tb_mpr121.sv */
`default_nettype none

module tb_mpr121
	import mpr121_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int BIT_CYCLES = 4 * SCL_QUARTER;  // one scl period
	localparam int OP_CYCLES  = 40 * BIT_CYCLES;  // rough length of one transaction
	localparam int HOLD_OPS   = 3;                // enable held this many transactions
	localparam int N_RANDOM   = 40;
	localparam int N_OPS      = 4 + 4 + 3 + 2 + HOLD_OPS + N_RANDOM;
	localparam int WATCHDOG_T = N_OPS * OP_CYCLES * CLK_PERIOD * 2;

	logic  clk;
	logic  rstn;
	byte_t reg_addr;
	byte_t wdata;
	logic  write_en;
	logic  read_en;
	logic  nak;         // model refuses acks
	byte_t rdata;
	logic  busy;
	logic  fail;
	logic  scl_low;
	logic  sda_low;
	logic  slv_sda_low;
	wire   scl_line;
	wire   sda_line;

	byte_t shadow [0:255]; // expected register contents
	byte_t last_rdata;
	byte_t exp_rdata;
	logic  exp_fail;
	int    errors;         // compare process
	int    checks;
	int    host_errors;    // reset and held enable checks
	int    host_checks;
	int    seed;
	int    rnd;
	event  op_done;

	// open-drain bus with pull-ups, only the DUT drives scl
	assign scl_line = !scl_low;
	assign sda_line = !(sda_low || slv_sda_low);

	mpr121_top i_dut (
		.i_CLK      (clk),
		.i_RSTN     (rstn),
		.i_reg_addr (reg_addr),
		.i_wdata    (wdata),
		.i_write_en (write_en),
		.i_read_en  (read_en),
		.i_scl      (scl_line),
		.i_sda      (sda_line),
		.o_rdata    (rdata),
		.o_busy     (busy),
		.o_fail     (fail),
		.o_scl_low  (scl_low),
		.o_sda_low  (sda_low)
	);

	mpr121_slave_model u_slave (
		.i_CLK     (clk),
		.i_RSTN    (rstn),
		.i_scl     (scl_line),
		.i_sda     (sda_line),
		.i_nak     (nak),
		.o_sda_low (slv_sda_low)
	);

	always #(CLK_PERIOD / 2) clk = !clk;

	//====================================================================
	// reference model and host handshake
	//====================================================================

	// expected rdata and fail after one host operation
	function automatic void predict_op(input logic is_write, input byte_t addr,
		input byte_t data, input logic refused, output byte_t rdata_o, output logic fail_o);
		fail_o = refused;
		if (!refused && is_write)
			shadow[addr] = data;
		else if (!refused)
			last_rdata = shadow[addr];
		rdata_o = last_rdata; // rdata moves on a good read only
	endfunction

	task automatic host_op(input logic is_write, input byte_t addr, input byte_t data,
		input int hold);
		@(posedge clk);
		#1;
		reg_addr = addr;
		wdata    = data;
		write_en = is_write;
		read_en  = !is_write;
		@(posedge clk);
		#1;
		while (!busy)
		begin
			@(posedge clk);
			#1;
		end
		while (busy)
		begin
			@(posedge clk);
			#1;
		end
		repeat (hold)
		begin
			@(posedge clk);
			#1;
			host_checks++;
			if (busy)
			begin
				host_errors++;
				$display("[FAIL] %0t: busy rose again with the enable held", $time);
			end
		end
		write_en = 1'b0;
		read_en  = 1'b0;
		predict_op(is_write, addr, data, nak, exp_rdata, exp_fail);
		-> op_done;
	endtask

	// compare after every operation
	always @(op_done)
	begin
		checks = checks + 2;
		if (rdata !== exp_rdata)
		begin
			errors++;
			$display("[FAIL] %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
		end
		if (fail !== exp_fail)
		begin
			errors++;
			$display("[FAIL] %0t: fail %b, expected %b", $time, fail, exp_fail);
		end
	end

	//====================================================================
	// stimulus
	//====================================================================
	initial
	begin
		clk         = 1'b0;
		rstn        = 1'b0;
		reg_addr    = '0;
		wdata       = '0;
		write_en    = 1'b0;
		read_en     = 1'b0;
		nak         = 1'b0;
		last_rdata  = '0;
		exp_rdata   = '0;
		exp_fail    = 1'b0;
		errors      = 0;
		checks      = 0;
		host_errors = 0;
		host_checks = 0;
		seed        = 32'ha0bb;
		for (int i = 0; i < 256; i++)
			shadow[i] = 8'(i) ^ 8'hA5; // slave power-up pattern
		repeat (10) @(posedge clk);
		#1;
		rstn = 1'b1;

		@(posedge clk);
		#1;
		host_checks++;
		if (busy || fail || rdata != 8'h00 || scl_low || sda_low)
		begin
			host_errors++;
			$display("[FAIL] %0t: outputs not idle after reset", $time);
		end

		// untouched registers
		host_op(1'b0, 8'h00, 8'h00, 0);
		host_op(1'b0, 8'h5E, 8'h00, 0);
		host_op(1'b0, 8'h80, 8'h00, 0);
		host_op(1'b0, 8'hFF, 8'h00, 0);

		// write, read back, neighbours unchanged
		host_op(1'b1, 8'h41, 8'h3C, 0);
		host_op(1'b0, 8'h41, 8'h00, 0);
		host_op(1'b0, 8'h40, 8'h00, 0);
		host_op(1'b0, 8'h42, 8'h00, 0);

		nak = 1'b1; // every ack refused
		host_op(1'b1, 8'h41, 8'hC3, 0);
		host_op(1'b0, 8'h10, 8'h00, 0);
		nak = 1'b0;
		host_op(1'b0, 8'h41, 8'h00, 0); // fail clears

		// held enable, one write only
		host_op(1'b1, 8'h22, 8'h99, HOLD_OPS * OP_CYCLES);
		host_op(1'b0, 8'h22, 8'h00, 0);

		for (int i = 0; i < N_RANDOM; i++)
		begin
			rnd = $random(seed);
			host_op(rnd[16], rnd[7:0], rnd[15:8], 0);
		end

		@(posedge clk);
		#1;
		$display("checks: %0d, errors: %0d", checks + host_checks, errors + host_errors);
		if (errors + host_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog, twice the expected run length
	initial
	begin
		#(WATCHDOG_T);
		$display("timeout: no end of test after %0d time units, a transaction hung",
			WATCHDOG_T);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/mpr121_pkg.sv
logic/i2c_bit_engine.sv
logic/i2c_byte_engine.sv
logic/mpr121_reg_access.sv
logic/mpr121_top.sv
dv/mpr121_slave_model.sv
dv/tb_mpr121.sv

/* run.sh */
#!/bin/sh
# compile and run the MPR121 controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_mpr121

out=$(./obj_dir/Vtb_mpr121) || true
echo "$out"
echo "$out" | grep -q "Test completed successfully"
